//--- rtl/lc3Pkg.sv
package lc3Pkg;

    // word, memory and register file sizes
    localparam int wordW    = 16;
    localparam int memDepth = 256;
    localparam int memAw    = $clog2(memDepth);
    localparam int regCnt   = 8;
    localparam int ledW     = 12;

    // pc input select
    localparam logic [1:0] pcInc   = 2'd0;
    localparam logic [1:0] pcBus   = 2'd1;
    localparam logic [1:0] pcAdder = 2'd2;

    // address adder offset select
    localparam logic [1:0] addr2Zero  = 2'd0;
    localparam logic [1:0] addr2Off6  = 2'd1;
    localparam logic [1:0] addr2Off9  = 2'd2;
    localparam logic [1:0] addr2Off11 = 2'd3;

    // LC-3 encodings, PAUSE sits on the TRAP-free slot 1101
    typedef enum logic [3:0] {
        opBr    = 4'b0000,
        opAdd   = 4'b0001,
        opLd    = 4'b0010,
        opSt    = 4'b0011,
        opAnd   = 4'b0101,
        opNot   = 4'b1001,
        opJmp   = 4'b1100,
        opPause = 4'b1101,
        opLea   = 4'b1110
    } opcodeE;

    typedef enum logic [4:0] {
        sFetch1, sFetch2, sFetch3, sDecode,
        sAdd, sAnd, sNot,
        sBr, sBrTaken, sJmp, sLea,
        sLd1, sLd2, sLd3,
        sSt1, sSt2, sSt3,
        sPause
    } stateE;

    typedef enum logic [1:0] {
        aluAdd, aluAnd, aluNot, aluPass
    } aluOpE;

    typedef struct packed {
        logic       ldMar;
        logic       ldMdr;
        logic       ldIr;
        logic       ldBen;
        logic       ldCc;
        logic       ldReg;
        logic       ldPc;
        logic       ldLed;
        logic       gatePc;
        logic       gateMdr;
        logic       gateAlu;
        logic       gateMarMux;
        logic       sr1Mux;
        logic       addr1Mux;
        logic [1:0] addr2Mux;
        logic [1:0] pcMux;
        aluOpE      aluK;
        logic       mioEn;
        logic       memWe;
    } ctrlT;

endpackage

//--- rtl/lc3RegFile.sv
module lc3RegFile (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      ldReg,
    input  logic [2:0]                dr,
    input  logic [2:0]                sr1,
    input  logic [2:0]                sr2,
    input  logic [lc3Pkg::wordW-1:0]  busData,
    output logic [lc3Pkg::wordW-1:0]  sr1Out,
    output logic [lc3Pkg::wordW-1:0]  sr2Out
);

    logic [lc3Pkg::wordW-1:0] regs [lc3Pkg::regCnt];

    // R0..R7, written from the bus
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < lc3Pkg::regCnt; i++) begin
                regs[i] <= '0;
            end
        end else if (ldReg) begin
            regs[dr] <= busData;
        end
    end

    // both reads are combinational
    assign sr1Out = regs[sr1];
    assign sr2Out = regs[sr2];

endmodule

//--- rtl/lc3Alu.sv
module lc3Alu (
    input  lc3Pkg::aluOpE             aluK,
    input  logic [lc3Pkg::wordW-1:0]  a,
    input  logic [lc3Pkg::wordW-1:0]  srcReg,
    input  logic [lc3Pkg::wordW-1:0]  ir,
    output logic [lc3Pkg::wordW-1:0]  result
);

    logic [lc3Pkg::wordW-1:0] imm5;
    logic [lc3Pkg::wordW-1:0] b;

    // imm5 sign extended from ir[4:0]
    assign imm5 = {{(lc3Pkg::wordW-5){ir[4]}}, ir[4:0]};

    // ir[5] picks the immediate form
    assign b = ir[5] ? imm5 : srcReg;

    always_comb begin
        case (aluK)
            lc3Pkg::aluAdd: begin
                result = a + b;
            end
            lc3Pkg::aluAnd: begin
                result = a & b;
            end
            lc3Pkg::aluNot: begin
                result = ~a;
            end
            default: begin
                result = a;
            end
        endcase
    end

endmodule

//--- rtl/lc3Datapath.sv
module lc3Datapath (
    input  logic                      Clk,
    input  logic                      arstN,
    input  lc3Pkg::ctrlT              ctrl,
    input  logic [lc3Pkg::wordW-1:0]  memRdata,
    output logic [lc3Pkg::wordW-1:0]  ir,
    output logic [lc3Pkg::wordW-1:0]  pc,
    output logic [lc3Pkg::wordW-1:0]  mar,
    output logic [lc3Pkg::wordW-1:0]  mdr,
    output logic [lc3Pkg::ledW-1:0]   led,
    output logic                      ben
);

    logic [lc3Pkg::wordW-1:0] irReg;
    logic [lc3Pkg::wordW-1:0] busData;
    logic [lc3Pkg::wordW-1:0] mdrView;
    logic [lc3Pkg::wordW-1:0] aluOut;
    logic [lc3Pkg::wordW-1:0] sr1Out;
    logic [lc3Pkg::wordW-1:0] sr2Out;
    logic [lc3Pkg::wordW-1:0] addr1;
    logic [lc3Pkg::wordW-1:0] addr2;
    logic [lc3Pkg::wordW-1:0] adderOut;
    logic [lc3Pkg::wordW-1:0] pcNext;
    logic [2:0]               sr1;
    logic [2:0]               nzp;
    logic [2:0]               nzpNext;

    // decode sees the instruction while it is being loaded
    assign ir = ctrl.ldIr ? busData : irReg;

    // with the memory enabled the MDR source shows the word being read
    assign mdrView = ctrl.mioEn ? memRdata : mdr;

    // gates are one-hot, idle bus reads zero
    always_comb begin
        busData = '0;
        if (ctrl.gatePc) begin
            busData = pc;
        end
        if (ctrl.gateMdr) begin
            busData = mdrView;
        end
        if (ctrl.gateAlu) begin
            busData = aluOut;
        end
        if (ctrl.gateMarMux) begin
            busData = adderOut;
        end
    end

    assign sr1 = ctrl.sr1Mux ? irReg[11:9] : irReg[8:6];

    lc3RegFile u_regFile (
        .Clk     (Clk),
        .arstN   (arstN),
        .ldReg   (ctrl.ldReg),
        .dr      (irReg[11:9]),
        .sr1     (sr1),
        .sr2     (irReg[2:0]),
        .busData (busData),
        .sr1Out  (sr1Out),
        .sr2Out  (sr2Out)
    );

    lc3Alu u_alu (
        .aluK   (ctrl.aluK),
        .a      (sr1Out),
        .srcReg (sr2Out),
        .ir     (irReg),
        .result (aluOut)
    );

    // address adder
    assign addr1 = ctrl.addr1Mux ? sr1Out : pc;

    always_comb begin
        case (ctrl.addr2Mux)
            lc3Pkg::addr2Off6:  addr2 = {{10{irReg[5]}}, irReg[5:0]};
            lc3Pkg::addr2Off9:  addr2 = {{7{irReg[8]}}, irReg[8:0]};
            lc3Pkg::addr2Off11: addr2 = {{5{irReg[10]}}, irReg[10:0]};
            default:            addr2 = '0;
        endcase
    end

    assign adderOut = addr1 + addr2;

    always_comb begin
        case (ctrl.pcMux)
            lc3Pkg::pcBus:   pcNext = busData;
            lc3Pkg::pcAdder: pcNext = adderOut;
            default:         pcNext = pc + 1'b1;
        endcase
    end

    assign nzpNext = {busData[15], busData == '0, !busData[15] && busData != '0};

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc    <= '0;
            irReg <= '0;
            mar   <= '0;
            mdr   <= '0;
            led   <= '0;
            nzp   <= 3'b010;
            ben   <= 1'b0;
        end else begin
            if (ctrl.ldPc) begin
                pc <= pcNext;
            end
            if (ctrl.ldIr) begin
                irReg <= busData;
            end
            if (ctrl.ldMar) begin
                mar <= busData;
            end
            if (ctrl.ldMdr) begin
                mdr <= ctrl.mioEn ? memRdata : busData;
            end
            if (ctrl.ldLed) begin
                led <= irReg[11:0];
            end
            if (ctrl.ldCc) begin
                nzp <= nzpNext;
            end
            if (ctrl.ldBen) begin
                ben <= |(ir[11:9] & nzp);
            end
        end
    end

endmodule

//--- rtl/lc3Control.sv
module lc3Control (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic [lc3Pkg::wordW-1:0]  ir,
    input  logic                      ben,
    input  logic                      cont,
    output lc3Pkg::ctrlT              ctrl,
    output logic                      halted
);

    lc3Pkg::stateE  state;
    lc3Pkg::stateE  stateNext;
    lc3Pkg::opcodeE opcode;

    assign opcode = lc3Pkg::opcodeE'(ir[15:12]);
    assign halted = (state == lc3Pkg::sPause);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= lc3Pkg::sFetch1;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = lc3Pkg::sFetch1;
        case (state)
            lc3Pkg::sFetch1: stateNext = lc3Pkg::sFetch2;
            lc3Pkg::sFetch2: stateNext = lc3Pkg::sFetch3;
            lc3Pkg::sFetch3: stateNext = lc3Pkg::sDecode;
            lc3Pkg::sDecode: begin
                case (opcode)
                    lc3Pkg::opAdd:   stateNext = lc3Pkg::sAdd;
                    lc3Pkg::opAnd:   stateNext = lc3Pkg::sAnd;
                    lc3Pkg::opNot:   stateNext = lc3Pkg::sNot;
                    lc3Pkg::opBr:    stateNext = lc3Pkg::sBr;
                    lc3Pkg::opJmp:   stateNext = lc3Pkg::sJmp;
                    lc3Pkg::opLea:   stateNext = lc3Pkg::sLea;
                    lc3Pkg::opLd:    stateNext = lc3Pkg::sLd1;
                    lc3Pkg::opSt:    stateNext = lc3Pkg::sSt1;
                    lc3Pkg::opPause: stateNext = lc3Pkg::sPause;
                    // unknown opcode runs as a no-op
                    default:         stateNext = lc3Pkg::sFetch1;
                endcase
            end
            lc3Pkg::sBr:     stateNext = ben ? lc3Pkg::sBrTaken : lc3Pkg::sFetch1;
            lc3Pkg::sLd1:    stateNext = lc3Pkg::sLd2;
            lc3Pkg::sLd2:    stateNext = lc3Pkg::sLd3;
            lc3Pkg::sSt1:    stateNext = lc3Pkg::sSt2;
            lc3Pkg::sSt2:    stateNext = lc3Pkg::sSt3;
            lc3Pkg::sPause:  stateNext = cont ? lc3Pkg::sFetch1 : lc3Pkg::sPause;
            default:         stateNext = lc3Pkg::sFetch1;
        endcase
    end

    // control word per state, everything idle unless set below
    always_comb begin
        ctrl = '0;
        case (state)
            lc3Pkg::sFetch1: begin
                ctrl.gatePc = 1'b1;
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
                ctrl.pcMux  = lc3Pkg::pcInc;
            end
            lc3Pkg::sFetch3: begin
                ctrl.ldMdr = 1'b1;
                ctrl.mioEn = 1'b1;
            end
            lc3Pkg::sDecode: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldIr    = 1'b1;
                ctrl.ldBen   = 1'b1;
            end
            lc3Pkg::sAdd, lc3Pkg::sAnd, lc3Pkg::sNot: begin
                ctrl.gateAlu = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
                if (state == lc3Pkg::sAdd) begin
                    ctrl.aluK = lc3Pkg::aluAdd;
                end else if (state == lc3Pkg::sAnd) begin
                    ctrl.aluK = lc3Pkg::aluAnd;
                end else begin
                    ctrl.aluK = lc3Pkg::aluNot;
                end
            end
            lc3Pkg::sBrTaken: begin
                ctrl.addr2Mux = lc3Pkg::addr2Off9;
                ctrl.pcMux    = lc3Pkg::pcAdder;
                ctrl.ldPc     = 1'b1;
            end
            lc3Pkg::sJmp: begin
                // base register plus zero through the adder
                ctrl.addr1Mux = 1'b1;
                ctrl.addr2Mux = lc3Pkg::addr2Zero;
                ctrl.pcMux    = lc3Pkg::pcAdder;
                ctrl.ldPc     = 1'b1;
            end
            lc3Pkg::sLea: begin
                // lea leaves the condition codes alone
                ctrl.addr2Mux   = lc3Pkg::addr2Off9;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldReg      = 1'b1;
            end
            lc3Pkg::sLd1, lc3Pkg::sSt1: begin
                ctrl.addr2Mux   = lc3Pkg::addr2Off9;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
            end
            lc3Pkg::sLd3: begin
                ctrl.mioEn   = 1'b1;
                ctrl.ldMdr   = 1'b1;
                ctrl.gateMdr = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
            end
            lc3Pkg::sSt2: begin
                // source register rides the alu pass-through into the MDR
                ctrl.sr1Mux  = 1'b1;
                ctrl.aluK    = lc3Pkg::aluPass;
                ctrl.gateAlu = 1'b1;
                ctrl.ldMdr   = 1'b1;
            end
            lc3Pkg::sSt3: begin
                ctrl.mioEn = 1'b1;
                ctrl.memWe = 1'b1;
            end
            lc3Pkg::sPause: begin
                ctrl.ldLed = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

//--- rtl/lc3Memory.sv
module lc3Memory (
    input  logic                      Clk,
    input  logic [lc3Pkg::wordW-1:0]  addr,
    input  logic [lc3Pkg::wordW-1:0]  wdata,
    input  logic                      we,
    output logic [lc3Pkg::wordW-1:0]  rdata,
    input  logic                      progWe,
    input  logic [lc3Pkg::wordW-1:0]  progAddr,
    input  logic [lc3Pkg::wordW-1:0]  progData,
    input  logic [lc3Pkg::wordW-1:0]  dbgAddr,
    output logic [lc3Pkg::wordW-1:0]  dbgData
);

    logic [lc3Pkg::wordW-1:0] mem [lc3Pkg::memDepth];

    // only the low address bits select a word
    always_ff @(posedge Clk) begin
        if (progWe) begin
            mem[progAddr[lc3Pkg::memAw-1:0]] <= progData;
        end else if (we) begin
            mem[addr[lc3Pkg::memAw-1:0]] <= wdata;
        end
        rdata <= mem[addr[lc3Pkg::memAw-1:0]];
    end

    // read-back for checking
    assign dbgData = mem[dbgAddr[lc3Pkg::memAw-1:0]];

endmodule

//--- rtl/lc3Top.sv
module lc3Top (
    input  logic                      Clk,
    input  logic                      arstN,
    input  logic                      cont,
    input  logic                      progWe,
    input  logic [lc3Pkg::wordW-1:0]  progAddr,
    input  logic [lc3Pkg::wordW-1:0]  progData,
    input  logic [lc3Pkg::wordW-1:0]  dbgAddr,
    output logic [lc3Pkg::wordW-1:0]  dbgData,
    output logic [lc3Pkg::ledW-1:0]   led,
    output logic [lc3Pkg::wordW-1:0]  pc,
    output logic                      halted
);

    lc3Pkg::ctrlT             ctrl;
    logic [lc3Pkg::wordW-1:0] ir;
    logic [lc3Pkg::wordW-1:0] mar;
    logic [lc3Pkg::wordW-1:0] mdr;
    logic [lc3Pkg::wordW-1:0] memRdata;
    logic                     ben;
    logic                     memWe;

    // no core write while the program is loaded under reset
    assign memWe = ctrl.mioEn & ctrl.memWe & arstN;

    lc3Control u_control (
        .Clk    (Clk),
        .arstN  (arstN),
        .ir     (ir),
        .ben    (ben),
        .cont   (cont),
        .ctrl   (ctrl),
        .halted (halted)
    );

    lc3Datapath u_datapath (
        .Clk      (Clk),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .ir       (ir),
        .pc       (pc),
        .mar      (mar),
        .mdr      (mdr),
        .led      (led),
        .ben      (ben)
    );

    lc3Memory u_memory (
        .Clk      (Clk),
        .addr     (mar),
        .wdata    (mdr),
        .we       (memWe),
        .rdata    (memRdata),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .dbgAddr  (dbgAddr),
        .dbgData  (dbgData)
    );

endmodule

//--- verif/lc3Tb.sv
module lc3Tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int nTests    = 11;
    localparam int imgWords  = 32;
    localparam int dataBase  = 16;
    localparam int maxPauses = 2;
    localparam int maxWait   = 2000;
    localparam int maxSteps  = 500;

    logic                      Clk;
    logic                      arstN;
    logic                      cont;
    logic                      progWe;
    logic [lc3Pkg::wordW-1:0]  progAddr;
    logic [lc3Pkg::wordW-1:0]  progData;
    logic [lc3Pkg::wordW-1:0]  dbgAddr;
    logic [lc3Pkg::wordW-1:0]  dbgData;
    logic [lc3Pkg::ledW-1:0]   led;
    logic [lc3Pkg::wordW-1:0]  pc;
    logic                      halted;

    // program at 0 and data from dataBase in each row's image
    logic [15:0] imgTab [nTests][imgWords];
    int          pauseTab [nTests];
    string       nameTab [nTests];

    // expected led and pc at each pause and the final memory words
    logic [11:0] expLedTab [nTests][maxPauses];
    logic [15:0] expPcTab [nTests][maxPauses];
    logic [15:0] expMemTab [nTests][imgWords];
    bit          expOkTab [nTests];

    // reference model state
    logic [15:0] mReg [8];
    logic [15:0] mMem [256];
    logic [15:0] mPc;
    logic [2:0]  mNzp;
    logic [11:0] mLed;

    logic [31:0] rngState;
    int          buildRow;
    int          buildPos;
    int          errCount;
    int          checkCount;

    lc3Top u_dut (
        .Clk      (Clk),
        .arstN    (arstN),
        .cont     (cont),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .dbgAddr  (dbgAddr),
        .dbgData  (dbgData),
        .led      (led),
        .pc       (pc),
        .halted   (halted)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
        logic [15:0] mask;
        mask = (16'd1 << bits) - 16'd1;
        if (v[bits-1]) begin
            return v | ~mask;
        end
        return v & mask;
    endfunction

    // offset from the word about to be emitted to an absolute target
    function automatic logic [8:0] off9(input int target);
        return 9'(target - buildPos - 1);
    endfunction

    function automatic logic [15:0] encAlu(input logic [3:0] op, input int dr, input int sr1,
                                           input bit imm, input int src);
        if (imm) begin
            return {op, 3'(dr), 3'(sr1), 1'b1, 5'(src)};
        end
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(src)};
    endfunction

    function automatic logic [15:0] encMem(input logic [3:0] op, input int r, input int target);
        return {op, 3'(r), off9(target)};
    endfunction

    function automatic logic [15:0] encBr(input logic [2:0] mask, input int target);
        return {4'(lc3Pkg::opBr), mask, off9(target)};
    endfunction

    function automatic logic [15:0] encNot(input int dr, input int sr);
        return {4'(lc3Pkg::opNot), 3'(dr), 3'(sr), 6'b111111};
    endfunction

    function automatic logic [15:0] encJmp(input int base);
        return {4'(lc3Pkg::opJmp), 3'b000, 3'(base), 6'b000000};
    endfunction

    function automatic logic [15:0] encPause(input logic [11:0] ledVal);
        return {4'(lc3Pkg::opPause), ledVal};
    endfunction

    task automatic emit(input logic [15:0] word);
        imgTab[buildRow][buildPos] = word;
        buildPos++;
    endtask

    task automatic buildTests();
        logic [2:0] cond;
        // pad words carry an address pattern and data words are random
        for (buildRow = 0; buildRow < nTests; buildRow++) begin
            pauseTab[buildRow] = 1;
            for (int a = 0; a < imgWords; a++) begin
                if (a < dataBase) begin
                    imgTab[buildRow][a] = {~8'(a), 8'(a)};
                end else begin
                    rngState = xorshift(rngState);
                    imgTab[buildRow][a] = rngState[15:0];
                end
            end
        end
        // rows 0 and 1 cover ADD or AND in both forms plus NOT
        for (int r = 0; r < 2; r++) begin
            logic [3:0] op;
            op = (r == 0) ? 4'(lc3Pkg::opAdd) : 4'(lc3Pkg::opAnd);
            nameTab[r] = (r == 0) ? "add and not" : "and and not";
            buildRow = r;
            buildPos = 0;
            rngState = xorshift(rngState);
            emit(encMem(lc3Pkg::opLd, 1, dataBase));
            emit(encMem(lc3Pkg::opLd, 2, dataBase + 1));
            emit(encAlu(op, 3, 1, 1'b0, 2));
            emit(encAlu(op, 4, 1, 1'b1, int'(rngState[4:0])));
            emit(encNot(5, 2));
            emit(encMem(lc3Pkg::opSt, 3, dataBase + 4));
            emit(encMem(lc3Pkg::opSt, 4, dataBase + 5));
            emit(encMem(lc3Pkg::opSt, 5, dataBase + 6));
            emit(encPause(12'h100 + 12'(r)));
        end
        // rows 2..7 branch on n, z and p both ways
        for (int c = 0; c < 3; c++) begin
            for (int tk = 0; tk < 2; tk++) begin
                buildRow = 2 + 2 * c + tk;
                buildPos = 0;
                cond = 3'b100 >> c;
                nameTab[buildRow] = $sformatf("br %s %s", (c == 0) ? "n" : (c == 1) ? "z" : "p",
                                              tk ? "taken" : "not taken");
                emit(encMem(lc3Pkg::opLd, 2, dataBase));
                emit(encMem(lc3Pkg::opLd, 3, dataBase + 1));
                emit(encAlu(lc3Pkg::opAnd, 1, 1, 1'b1, 0));
                emit(encAlu(lc3Pkg::opAdd, 1, 1, 1'b1, c - 1));
                emit(encBr(tk ? cond : ~cond, 7));
                emit(encMem(lc3Pkg::opSt, 2, dataBase + 4));
                emit(encPause(12'h200 + 12'(buildRow)));
                emit(encMem(lc3Pkg::opSt, 3, dataBase + 4));
                emit(encPause(12'h280 + 12'(buildRow)));
            end
        end
        // row 8 builds the target with LEA and skips the first store with JMP
        buildRow = 8;
        buildPos = 0;
        nameTab[8] = "lea and jmp";
        emit(encMem(lc3Pkg::opLd, 2, dataBase));
        emit(encMem(lc3Pkg::opLea, 4, 5));
        emit(encJmp(4));
        emit(encMem(lc3Pkg::opSt, 2, dataBase + 4));
        emit(encPause(12'h3ee));
        emit(encMem(lc3Pkg::opSt, 4, dataBase + 5));
        emit(encPause(12'h301));
        // row 9 has two pauses resumed by cont
        buildRow = 9;
        buildPos = 0;
        nameTab[9] = "pause and continue";
        pauseTab[9] = 2;
        emit(encMem(lc3Pkg::opLd, 1, dataBase));
        emit(encPause(12'h4a5));
        emit(encAlu(lc3Pkg::opAdd, 1, 1, 1'b1, 3));
        emit(encMem(lc3Pkg::opSt, 1, dataBase + 4));
        emit(encPause(12'h45a));
        // row 10 stores R3 which only earlier rows wrote
        buildRow = 10;
        buildPos = 0;
        nameTab[10] = "reset clears registers";
        emit(encMem(lc3Pkg::opSt, 3, dataBase + 4));
        emit(encPause(12'h5c3));
        for (int t = 0; t < nTests; t++) begin
            predictRow(t);
        end
    endtask

    // n for negative, z for zero, p otherwise
    task automatic setReg(input logic [2:0] dr, input logic [15:0] v);
        mReg[dr] = v;
        if (v[15]) begin
            mNzp = 3'b100;
        end else if (v == 16'h0000) begin
            mNzp = 3'b010;
        end else begin
            mNzp = 3'b001;
        end
    endtask

    // ISA-level model that runs to the next PAUSE
    task automatic modelRun(output bit ok);
        logic [15:0] ins;
        logic [15:0] val;
        logic [15:0] ea;
        ok = 1'b0;
        for (int step = 0; step < maxSteps; step++) begin
            ins = mMem[mPc[7:0]];
            mPc = mPc + 16'd1;
            val = ins[5] ? sext(ins, 5) : mReg[ins[2:0]];
            ea = mPc + sext(ins, 9);
            case (ins[15:12])
                lc3Pkg::opAdd: setReg(ins[11:9], mReg[ins[8:6]] + val);
                lc3Pkg::opAnd: setReg(ins[11:9], mReg[ins[8:6]] & val);
                lc3Pkg::opNot: setReg(ins[11:9], ~mReg[ins[8:6]]);
                lc3Pkg::opLd:  setReg(ins[11:9], mMem[ea[7:0]]);
                lc3Pkg::opSt:  mMem[ea[7:0]] = mReg[ins[11:9]];
                lc3Pkg::opLea: mReg[ins[11:9]] = ea;
                lc3Pkg::opJmp: mPc = mReg[ins[8:6]];
                lc3Pkg::opBr: begin
                    if ((ins[11:9] & mNzp) != 3'b000) begin
                        mPc = ea;
                    end
                end
                lc3Pkg::opPause: begin
                    mLed = ins[11:0];
                    ok = 1'b1;
                    return;
                end
                default: begin
                end
            endcase
        end
    endtask

    // runs one row's image from reset through the model
    task automatic predictRow(input int t);
        bit ok;
        for (int i = 0; i < 8; i++) begin
            mReg[i] = 16'h0000;
        end
        for (int a = 0; a < 256; a++) begin
            mMem[a] = (a < imgWords) ? imgTab[t][a] : 16'h0000;
        end
        mPc = 16'h0000;
        mNzp = 3'b010;
        mLed = 12'h000;
        expOkTab[t] = 1'b1;
        for (int p = 0; p < pauseTab[t]; p++) begin
            modelRun(ok);
            if (!ok) begin
                expOkTab[t] = 1'b0;
            end
            expLedTab[t][p] = mLed;
            expPcTab[t][p] = mPc;
        end
        for (int a = 0; a < imgWords; a++) begin
            expMemTab[t][a] = mMem[a];
        end
    endtask

    task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic runTest(input int t);
        int errStart;
        int waitCnt;
        errStart = errCount;
        // image goes in while the core is held in reset
        @(negedge Clk);
        arstN = 1'b0;
        for (int a = 0; a < imgWords; a++) begin
            progWe = 1'b1;
            progAddr = 16'(a);
            progData = imgTab[t][a];
            @(negedge Clk);
        end
        progWe = 1'b0;
        repeat (10) @(negedge Clk);
        checkEq("pc", pc, 16'h0000);
        checkEq("led", 16'(led), 16'h0000);
        checkEq("halted", 16'(halted), 16'h0000);
        if (!expOkTab[t]) begin
            $display("test %0d: reference model did not reach PAUSE", t);
            errCount++;
        end
        arstN = 1'b1;
        for (int p = 0; p < pauseTab[t]; p++) begin
            waitCnt = 0;
            while (!halted && waitCnt < maxWait) begin
                @(negedge Clk);
                waitCnt++;
            end
            if (!halted) begin
                $display("test %0d: core did not reach PAUSE", t);
                errCount++;
                break;
            end
            // led loads one cycle into the pause state
            @(negedge Clk);
            checkEq("led", 16'(led), 16'(expLedTab[t][p]));
            checkEq("pc", pc, expPcTab[t][p]);
            if (p < pauseTab[t] - 1) begin
                cont = 1'b1;
                @(negedge Clk);
                cont = 1'b0;
            end
        end
        for (int a = dataBase; a < imgWords; a++) begin
            @(negedge Clk);
            dbgAddr = 16'(a);
            #1;
            checkEq($sformatf("mem[%0d]", a), dbgData, expMemTab[t][a]);
        end
        $display("test %0d %s: %s", t, nameTab[t], (errCount == errStart) ? "ok" : "failed");
    endtask

    initial begin
        arstN = 1'b0;
        cont = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        dbgAddr = '0;
        errCount = 0;
        checkCount = 0;
        rngState = 32'h8b91;
        buildTests();
        for (int t = 0; t < nTests; t++) begin
            runTest(t);
        end
        $display("tests %0d, checks %0d, failures %0d", nTests, checkCount, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/lc3Pkg.sv
rtl/lc3RegFile.sv
rtl/lc3Alu.sv
rtl/lc3Datapath.sv
rtl/lc3Control.sv
rtl/lc3Memory.sv
rtl/lc3Top.sv
verif/lc3Tb.sv

//--- Bender.yml
package:
  name: lc3

sources:
  - rtl/lc3Pkg.sv
  - rtl/lc3RegFile.sv
  - rtl/lc3Alu.sv
  - rtl/lc3Datapath.sv
  - rtl/lc3Control.sv
  - rtl/lc3Memory.sv
  - rtl/lc3Top.sv
  - target: test
    files:
      - verif/lc3Tb.sv
